// File: Makefile
# verilator build and run for the uart testbench
VERILATOR ?= verilator
TOP       ?= tb_uart_top
FILELIST  ?= uart_top.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing

SIM_BIN := $(BUILD_DIR)/V$(TOP)

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with verilator, run and check $(LOG)"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "  help   show this list"

$(SIM_BIN): $(FILELIST) $(shell cat $(FILELIST))
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

test: $(SIM_BIN)
	$(SIM_BIN) | tee $(LOG)
	@grep -q "Testbench passed" $(LOG) || (echo "simulation did not pass, see $(LOG)"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: tb_uart_top.sv
// --------------------
// uart testbench
// directed tests for register access, tx/rx framing, fifo
// overrun, interrupts and rts/cts flow control
// --------------------
`timescale 1ns/1ps

module tb_uart_top;

    localparam int CLK_PERIOD = 40;             // ns
    localparam int BIT_CLKS   = 8;              // (baud 3 + 1) * 2^(prsc 0 + 1)
    localparam int FRAME_CLKS = 11 * BIT_CLKS;  // start, 8 data, stop, pause
    localparam int TIMEOUT_NS = 6 * 8 * FRAME_CLKS * CLK_PERIOD * 2;
    localparam int SEED       = 51570;

    localparam logic [31:0] CTRL_RUN = 32'h0000_00C1; // en, prsc 0, baud 3
    localparam logic [31:0] CTRL_MIX = 32'h0580_A96D; // en, hwfc, prsc 5, baud 2a5, irq 10110
    localparam logic [31:0] WR_MASK  = 32'h07C0_FFFD; // all r/w fields
    localparam logic [31:0] TX_IDLE  = 32'h0018_0000; // tx empty, tx not half
    localparam logic [31:0] RX_NEMPTY = 32'd1 << uart_pkg::CTRL_RX_NEMPTY;
    localparam logic [31:0] RX_HALF   = 32'd1 << uart_pkg::CTRL_RX_HALF;
    localparam logic [31:0] RX_FULL   = 32'd1 << uart_pkg::CTRL_RX_FULL;
    localparam logic [31:0] RX_OVER   = 32'd1 << uart_pkg::CTRL_RX_OVER;

    logic        clk_i = 1'b0;
    logic        rstn_i;
    logic [2:0]  addr_i;
    logic        rden_i, wren_i;
    logic [31:0] data_i, data_o;
    logic        ack_o;
    logic        uart_txd_o, uart_rxd_i, uart_rts_o, uart_cts_i;
    logic        irq_rx_o, irq_tx_o;
    string       test_name;

    uart_top dut_i (.*);

    always #(CLK_PERIOD / 2) clk_i = ~clk_i;

    // helpers --------------
    task automatic abort_run(input string msg);
        $display("%s", msg);
        $display("Testbench failed");
        $fatal(1);
    endtask

    task automatic check(input string what, input logic [31:0] exp, input logic [31:0] act);
        if (exp !== act) begin
            abort_run($sformatf("** Error [%s] %s: expected %08h, actual %08h",
                                test_name, what, exp, act));
        end
    endtask

    task automatic wait_cycles(input int n);
        repeat (n) @(posedge clk_i);
    endtask

    task automatic wait_ack(input string what);
        int n;
        n = 0;
        @(negedge clk_i);
        while (ack_o !== 1'b1) begin
            if (n == 4) abort_run({"bus gave no ack for a ", what});
            n++;
            @(negedge clk_i);
        end
    endtask

    task automatic bus_write(input logic [2:0] addr, input logic [31:0] wdata);
        @(posedge clk_i);
        addr_i <= addr;
        data_i <= wdata;
        wren_i <= 1'b1;
        @(posedge clk_i);
        wren_i <= 1'b0;   // single pulse
        wait_ack("write");
    endtask

    task automatic bus_read(input logic [2:0] addr, output logic [31:0] rdata);
        @(posedge clk_i);
        addr_i <= addr;
        rden_i <= 1'b1;
        @(posedge clk_i);
        rden_i <= 1'b0;
        wait_ack("read");
        rdata = data_o;   // sampled mid-cycle with ack
    endtask

    task automatic read_check(input logic [2:0] addr, input logic [31:0] exp,
                              input string what);
        logic [31:0] rd;
        bus_read(addr, rd);
        check(what, exp, rd);
    endtask

    // serial side ----------
    task automatic send_frame(input logic [7:0] b);
        logic [9:0] bits;
        int         i;
        bits = {1'b1, b, 1'b0}; // stop, data, start
        for (i = 0; i < 10; i++) begin
            @(posedge clk_i);
            uart_rxd_i <= bits[i];
            repeat (BIT_CLKS - 1) @(posedge clk_i);
        end
        repeat (BIT_CLKS) @(posedge clk_i); // one idle bit between frames
    endtask

    task automatic get_frame(output logic [7:0] b);
        int         n;
        int         i;
        logic [7:0] data;
        n = 0;
        @(negedge clk_i);
        while (uart_txd_o !== 1'b0) begin
            if (n == 4 * FRAME_CLKS) abort_run("no start bit appeared on txd");
            n++;
            @(negedge clk_i);
        end
        repeat (BIT_CLKS / 2) @(negedge clk_i); // centre of start bit
        check("start bit", 32'd0, {31'b0, uart_txd_o});
        for (i = 0; i < 8; i++) begin
            repeat (BIT_CLKS) @(negedge clk_i);
            data[i] = uart_txd_o; // lsb first
        end
        repeat (BIT_CLKS) @(negedge clk_i);
        check("stop bit", 32'd1, {31'b0, uart_txd_o});
        b = data;
    endtask

    task automatic check_txd_idle(input int cycles);
        repeat (cycles) begin
            @(negedge clk_i);
            check("txd idle while cts high", 32'd1, {31'b0, uart_txd_o});
        end
    endtask

    // tests ----------------
    task automatic test_reset_readback();
        logic [31:0] wval;
        test_name = "reset_readback";
        wval = CTRL_MIX | 32'hF83F_0002; // read-only and unused bits set too
        check("txd idle", 32'd1, {31'b0, uart_txd_o});
        check("ack/irq/rts low", 32'd0, {28'b0, ack_o, irq_rx_o, irq_tx_o, uart_rts_o});
        check("data_o idle", 32'd0, data_o);
        read_check(uart_pkg::CTRL_ADDR, TX_IDLE, "ctrl after reset");
        bus_write(uart_pkg::CTRL_ADDR, wval);
        read_check(uart_pkg::CTRL_ADDR, (wval & WR_MASK) | TX_IDLE, "ctrl readback");
        bus_write(uart_pkg::CTRL_ADDR, 32'd0);
    endtask

    task automatic test_transmit();
        logic [7:0]  b, got;
        logic [31:0] rd;
        test_name = "transmit";
        b = 8'($urandom());
        bus_write(uart_pkg::CTRL_ADDR, CTRL_RUN);
        bus_write(uart_pkg::DATA_ADDR, {24'b0, b});
        fork
            get_frame(got);
            begin
                wait_cycles(3 * BIT_CLKS); // somewhere in the data bits
                bus_read(uart_pkg::CTRL_ADDR, rd);
                check("busy in frame", 32'd1, {31'b0, rd[uart_pkg::CTRL_TX_BUSY]});
            end
        join
        check("tx byte", {24'b0, b}, {24'b0, got});
        wait_cycles(2 * BIT_CLKS); // rest of stop and pause bit
        read_check(uart_pkg::CTRL_ADDR, CTRL_RUN | TX_IDLE, "busy after frame");
        check("irq_tx masked", 32'd0, {31'b0, irq_tx_o});
    endtask

    task automatic test_receive();
        logic [7:0]  b;
        logic [31:0] ctrl;
        test_name = "receive";
        b    = 8'($urandom());
        ctrl = CTRL_RUN | (32'd1 << uart_pkg::CTRL_IRQ_RX_NEMPTY);
        bus_write(uart_pkg::CTRL_ADDR, ctrl);
        read_check(uart_pkg::CTRL_ADDR, ctrl | TX_IDLE, "rx empty");
        check("irq_rx idle", 32'd0, {31'b0, irq_rx_o});
        send_frame(b);
        read_check(uart_pkg::CTRL_ADDR, ctrl | TX_IDLE | RX_NEMPTY, "rx not empty");
        check("irq_rx pending", 32'd1, {31'b0, irq_rx_o});
        read_check(uart_pkg::DATA_ADDR, {24'b0, b}, "rx byte");
        read_check(uart_pkg::CTRL_ADDR, ctrl | TX_IDLE, "rx drained");
        check("irq_rx cleared", 32'd0, {31'b0, irq_rx_o});
    endtask

    task automatic test_overrun();
        logic [7:0] bytes [5];
        int         i;
        test_name = "overrun";
        bus_write(uart_pkg::CTRL_ADDR, CTRL_RUN);
        for (i = 0; i < 5; i++) begin
            bytes[i] = 8'($urandom());
            send_frame(bytes[i]); // fifth one is dropped
        end
        read_check(uart_pkg::CTRL_ADDR,
                   CTRL_RUN | TX_IDLE | RX_NEMPTY | RX_HALF | RX_FULL | RX_OVER, "rx full");
        check("irq_rx masked", 32'd0, {31'b0, irq_rx_o});
        read_check(uart_pkg::DATA_ADDR, {24'b0, bytes[0]}, "rx byte 0");
        read_check(uart_pkg::CTRL_ADDR, CTRL_RUN | TX_IDLE | RX_NEMPTY | RX_HALF,
                   "overrun cleared");
        for (i = 1; i < 4; i++) begin
            read_check(uart_pkg::DATA_ADDR, {24'b0, bytes[i]}, $sformatf("rx byte %0d", i));
        end
        read_check(uart_pkg::CTRL_ADDR, CTRL_RUN | TX_IDLE, "rx drained");
    endtask

    task automatic test_tx_irq();
        logic [7:0] bytes [4];
        logic [7:0] got;
        int         i;
        test_name = "tx_irq";
        bus_write(uart_pkg::CTRL_ADDR, CTRL_RUN | (32'd1 << uart_pkg::CTRL_IRQ_TX_EMPTY));
        repeat (2) @(negedge clk_i);
        check("irq_tx idle", 32'd1, {31'b0, irq_tx_o});
        for (i = 0; i < 4; i++) bytes[i] = 8'($urandom());
        fork
            for (int k = 0; k < 4; k++) begin
                get_frame(got);
                check($sformatf("tx byte %0d", k), {24'b0, bytes[k]}, {24'b0, got});
            end
            begin
                for (i = 0; i < 4; i++) bus_write(uart_pkg::DATA_ADDR, {24'b0, bytes[i]});
                repeat (2) @(negedge clk_i);
                check("irq_tx busy", 32'd0, {31'b0, irq_tx_o});
            end
        join
        repeat (2) @(negedge clk_i);
        check("irq_tx back", 32'd1, {31'b0, irq_tx_o});
        wait_cycles(2 * BIT_CLKS); // let the pause bit finish
    endtask

    task automatic test_flow_control();
        logic [7:0] b, b0, b1, got;
        test_name = "flow_control";
        b  = 8'($urandom());
        b0 = 8'($urandom());
        b1 = 8'($urandom());
        @(posedge clk_i);
        uart_cts_i <= 1'b1; // far end not ready
        bus_write(uart_pkg::CTRL_ADDR, CTRL_RUN | (32'd1 << uart_pkg::CTRL_HWFC));
        bus_write(uart_pkg::DATA_ADDR, {24'b0, b});
        check_txd_idle(3 * FRAME_CLKS);
        @(posedge clk_i);
        uart_cts_i <= 1'b0;
        get_frame(got);
        check("released byte", {24'b0, b}, {24'b0, got});
        wait_cycles(2 * BIT_CLKS);
        @(negedge clk_i);
        check("rts empty", 32'd0, {31'b0, uart_rts_o});
        send_frame(b0);
        @(negedge clk_i);
        check("rts one byte", 32'd0, {31'b0, uart_rts_o});
        send_frame(b1);
        @(negedge clk_i);
        check("rts half", 32'd1, {31'b0, uart_rts_o});
        read_check(uart_pkg::DATA_ADDR, {24'b0, b0}, "rx byte 0");
        read_check(uart_pkg::DATA_ADDR, {24'b0, b1}, "rx byte 1");
        repeat (2) @(negedge clk_i);
        check("rts drained", 32'd0, {31'b0, uart_rts_o});
    endtask

    // main sequence --------
    initial begin
        rstn_i     = 1'b0;
        addr_i     = '0;
        rden_i     = 1'b0;
        wren_i     = 1'b0;
        data_i     = '0;
        uart_rxd_i = 1'b1; // line idle
        uart_cts_i = 1'b0;
        test_name  = "reset";
        void'($urandom(SEED));
        repeat (10) @(posedge clk_i);
        rstn_i <= 1'b1;
        @(negedge clk_i);
        test_reset_readback();
        test_transmit();
        test_receive();
        test_overrun();
        test_tx_irq();
        test_flow_control();
        $display("Testbench passed");
        $finish;
    end

    // watchdog
    initial begin
        #(TIMEOUT_NS);
        abort_run("watchdog timeout, the tests did not finish in time");
    end

endmodule

// File: uart_baud_tick.sv
// --------------------
// uart baud tick
// free-running prescaler, one-cycle tick every
// 2^(prsc+1) clocks
// --------------------
`timescale 1ns/1ps

module uart_baud_tick (
    input  logic                       clk_i,
    input  logic                       rstn_i,
    input  logic                       enable_i,
    input  logic [uart_pkg::PRSC_W-1:0] prsc_i, // selects counter bit
    output logic                       tick_o
);
    logic [11:0] cnt;
    logic        sel_q; // selected bit, last cycle

    always_ff @(posedge clk_i or negedge rstn_i) begin
        if (!rstn_i) begin
            cnt   <= '0;
            sel_q <= 1'b0;
        end else if (!enable_i) begin
            cnt   <= '0; // held while disabled
            sel_q <= 1'b0;
        end else begin
            cnt   <= cnt + 1'b1;
            sel_q <= cnt[prsc_i];
        end
    end

    assign tick_o = cnt[prsc_i] & ~sel_q; // 0 -> 1 edge

endmodule

// File: uart_fifo.sv
// --------------------
// uart fifo
// circular buffer with synchronous read, fill flags
// and a synchronous clear, used for rx and tx
// --------------------
`timescale 1ns/1ps

module uart_fifo #(
    parameter int DEPTH = 4 // power of two, min 2
) (
    input  logic                       clk_i,
    input  logic                       rstn_i,
    input  logic                       clear_i, // sync flush
    input  logic                       we_i,
    input  logic [uart_pkg::DATA_W-1:0] wdata_i,
    input  logic                       re_i,
    output logic [uart_pkg::DATA_W-1:0] rdata_o, // valid one cycle after re
    output logic                       free_o,  // at least one slot free
    output logic                       avail_o, // at least one entry held
    output logic                       half_o   // at least DEPTH/2 held
);
    localparam int AW = $clog2(DEPTH);

    logic [uart_pkg::DATA_W-1:0] mem [DEPTH];
    logic [AW:0] wptr, rptr; // extra msb tells full from empty
    logic [AW:0] level;
    logic        we_ok, re_ok;

    assign level   = wptr - rptr;
    assign avail_o = (wptr != rptr);
    assign free_o  = ~((wptr[AW] != rptr[AW]) && (wptr[AW-1:0] == rptr[AW-1:0]));
    assign half_o  = level[AW] | level[AW-1]; // level >= DEPTH/2
    assign we_ok   = we_i & free_o;  // drop writes when full
    assign re_ok   = re_i & avail_o; // ignore reads when empty

    always_ff @(posedge clk_i or negedge rstn_i) begin
        if (!rstn_i) begin
            wptr <= '0;
            rptr <= '0;
        end else if (clear_i) begin
            wptr <= '0;
            rptr <= '0;
        end else begin
            if (we_ok) wptr <= wptr + 1'b1;
            if (re_ok) rptr <= rptr + 1'b1;
        end
    end

    // storage and read register, no reset
    always_ff @(posedge clk_i) begin
        if (we_ok) mem[wptr[AW-1:0]] <= wdata_i;
        if (re_ok) rdata_o <= mem[rptr[AW-1:0]];
    end

endmodule

// File: uart_pkg.sv
// --------------------
// uart package
// register offsets, control bit positions, field widths
// and frame/fifo constants shared by the uart blocks
// --------------------
package uart_pkg;

    // widths --------------
    localparam int DATA_W = 8;  // serial data byte
    localparam int BAUD_W = 10; // baud divisor field
    localparam int PRSC_W = 3;  // prescaler select field
    localparam int ADDR_W = 3;  // bus word offset
    localparam int BUS_W  = 32; // bus data

    // register offsets ----
    localparam logic [ADDR_W-1:0] CTRL_ADDR = 3'd0; // control / status
    localparam logic [ADDR_W-1:0] DATA_ADDR = 3'd4; // rx/tx data

    // control register ----
    localparam int CTRL_EN            = 0;  // r/w uart enable
    localparam int CTRL_HWFC          = 2;  // r/w rts/cts enable
    localparam int CTRL_PRSC_LSB      = 3;  // r/w prescaler, bits 5:3
    localparam int CTRL_BAUD_LSB      = 6;  // r/w baud divisor, bits 15:6
    localparam int CTRL_RX_NEMPTY     = 16; // r/- rx fifo not empty
    localparam int CTRL_RX_HALF       = 17; // r/- rx fifo at least half full
    localparam int CTRL_RX_FULL       = 18; // r/- rx fifo full
    localparam int CTRL_TX_EMPTY      = 19; // r/- tx fifo empty
    localparam int CTRL_TX_NHALF      = 20; // r/- tx fifo below half
    localparam int CTRL_TX_FULL       = 21; // r/- tx fifo full
    localparam int CTRL_IRQ_RX_NEMPTY = 22; // r/w irq on rx not empty
    localparam int CTRL_IRQ_RX_HALF   = 23; // r/w irq on rx half
    localparam int CTRL_IRQ_RX_FULL   = 24; // r/w irq on rx full
    localparam int CTRL_IRQ_TX_EMPTY  = 25; // r/w irq on tx empty
    localparam int CTRL_IRQ_TX_NHALF  = 26; // r/w irq on tx not half
    localparam int CTRL_RX_OVER       = 30; // r/- rx overrun
    localparam int CTRL_TX_BUSY       = 31; // r/- engine busy or fifo not empty

    // frame and fifo ------
    localparam logic [3:0] TX_BITS = 4'd11; // start + 8 data + stop + pause
    localparam logic [3:0] RX_BITS = 4'd10; // start + 8 data + stop
    localparam int FIFO_DEPTH = 4;          // entries per direction

endpackage

// File: uart_regs.sv
// --------------------
// uart control
// control register, status readback, fifo strobes,
// level interrupts, rx overrun and rts
// --------------------
`timescale 1ns/1ps

module uart_regs (
    input  logic                       clk_i,
    input  logic                       rstn_i,
    input  logic [uart_pkg::ADDR_W-1:0] addr_i,
    input  logic                       rden_i,
    input  logic                       wren_i,
    input  logic [uart_pkg::BUS_W-1:0]  data_i,
    output logic [uart_pkg::BUS_W-1:0]  data_o,
    output logic                       ack_o,
    input  logic [uart_pkg::DATA_W-1:0] rx_rdata_i,
    input  logic                       rx_avail_i,
    input  logic                       rx_half_i,
    input  logic                       rx_free_i,
    input  logic                       tx_avail_i,
    input  logic                       tx_half_i,
    input  logic                       tx_free_i,
    input  logic                       tx_busy_i,
    input  logic                       rx_done_i,
    output logic                       enable_o,
    output logic                       fifo_clear_o,
    output logic                       hwfc_en_o,
    output logic [uart_pkg::PRSC_W-1:0] prsc_o,
    output logic [uart_pkg::BAUD_W-1:0] baud_o,
    output logic                       tx_we_o,
    output logic                       rx_re_o,
    output logic                       irq_rx_o,
    output logic                       irq_tx_o,
    output logic                       uart_rts_o
);
    logic [4:0]                  irq_en;  // rx nempty/half/full, tx empty/nhalf
    logic                        rx_over;
    logic                        rden_q;  // fifo read takes a cycle
    logic [uart_pkg::ADDR_W-1:0] addr_q;
    logic [uart_pkg::BUS_W-1:0]  rd_word;

    assign fifo_clear_o = ~enable_o; // flush while disabled
    assign tx_we_o      = wren_i & (addr_i == uart_pkg::DATA_ADDR);
    assign rx_re_o      = rden_i & (addr_i == uart_pkg::DATA_ADDR);

    // control register --------
    always_ff @(posedge clk_i or negedge rstn_i) begin
        if (!rstn_i) begin
            enable_o  <= 1'b0;
            hwfc_en_o <= 1'b0;
            prsc_o    <= '0;
            baud_o    <= '0;
            irq_en    <= '0;
        end else if (wren_i && addr_i == uart_pkg::CTRL_ADDR) begin
            enable_o  <= data_i[uart_pkg::CTRL_EN];
            hwfc_en_o <= data_i[uart_pkg::CTRL_HWFC];
            prsc_o    <= data_i[uart_pkg::CTRL_PRSC_LSB +: uart_pkg::PRSC_W];
            baud_o    <= data_i[uart_pkg::CTRL_BAUD_LSB +: uart_pkg::BAUD_W];
            irq_en    <= data_i[uart_pkg::CTRL_IRQ_TX_NHALF:uart_pkg::CTRL_IRQ_RX_NEMPTY];
        end
    end

    // readback word -----------
    always_comb begin
        rd_word = '0;
        if (addr_q == uart_pkg::CTRL_ADDR) begin
            rd_word[uart_pkg::CTRL_EN]                               = enable_o;
            rd_word[uart_pkg::CTRL_HWFC]                             = hwfc_en_o;
            rd_word[uart_pkg::CTRL_PRSC_LSB +: uart_pkg::PRSC_W]     = prsc_o;
            rd_word[uart_pkg::CTRL_BAUD_LSB +: uart_pkg::BAUD_W]     = baud_o;
            rd_word[uart_pkg::CTRL_RX_NEMPTY]                        = rx_avail_i;
            rd_word[uart_pkg::CTRL_RX_HALF]                          = rx_half_i;
            rd_word[uart_pkg::CTRL_RX_FULL]                          = ~rx_free_i;
            rd_word[uart_pkg::CTRL_TX_EMPTY]                         = ~tx_avail_i;
            rd_word[uart_pkg::CTRL_TX_NHALF]                         = ~tx_half_i;
            rd_word[uart_pkg::CTRL_TX_FULL]                          = ~tx_free_i;
            rd_word[uart_pkg::CTRL_IRQ_TX_NHALF:uart_pkg::CTRL_IRQ_RX_NEMPTY] = irq_en;
            rd_word[uart_pkg::CTRL_RX_OVER]                          = rx_over;
            rd_word[uart_pkg::CTRL_TX_BUSY]                          = tx_busy_i | tx_avail_i;
        end else if (addr_q == uart_pkg::DATA_ADDR) begin
            rd_word[uart_pkg::DATA_W-1:0] = rx_rdata_i; // fifo head, stale if empty
        end
    end

    // bus response, irq, overrun, rts
    always_ff @(posedge clk_i or negedge rstn_i) begin
        if (!rstn_i) begin
            rden_q     <= 1'b0;
            addr_q     <= '0;
            ack_o      <= 1'b0;
            data_o     <= '0;
            irq_rx_o   <= 1'b0;
            irq_tx_o   <= 1'b0;
            rx_over    <= 1'b0;
            uart_rts_o <= 1'b0;
        end else begin
            rden_q <= rden_i;
            addr_q <= addr_i;
            ack_o  <= wren_i | rden_q;          // write +1, read +2
            data_o <= rden_q ? rd_word : '0;    // zero outside ack
            irq_rx_o <= enable_o & ((irq_en[0] & rx_avail_i) |
                                    (irq_en[1] & rx_half_i) |
                                    (irq_en[2] & ~rx_free_i));
            irq_tx_o <= enable_o & ((irq_en[3] & ~tx_avail_i) |
                                    (irq_en[4] & ~tx_half_i));
            if (rx_re_o || !enable_o) begin
                rx_over <= 1'b0;
            end else if (rx_done_i && !rx_free_i) begin
                rx_over <= 1'b1; // byte dropped
            end
            uart_rts_o <= hwfc_en_o & (~enable_o | rx_half_i); // high = stop sending
        end
    end

endmodule

// File: uart_rx.sv
// --------------------
// uart receive engine
// synchronizes rxd, detects the start edge and samples
// each bit in its middle, one done strobe per frame
// --------------------
`timescale 1ns/1ps

module uart_rx (
    input  logic                       clk_i,
    input  logic                       rstn_i,
    input  logic                       enable_i,
    input  logic                       tick_i,
    input  logic [uart_pkg::BAUD_W-1:0] baud_i,
    input  logic                       uart_rxd_i,
    output logic                       rx_done_o, // one cycle, write to rx fifo
    output logic [uart_pkg::DATA_W-1:0] rx_data_o
);
    logic [2:0]                  sync;     // [2] every clock, [1:0] on tick
    logic                        busy;     // frame in progress
    logic [uart_pkg::DATA_W+1:0] sreg;     // stop, data, start
    logic [3:0]                  bitcnt;
    logic [uart_pkg::BAUD_W-1:0] baudcnt;

    assign rx_data_o = sreg[uart_pkg::DATA_W:1]; // strip start and stop

    always_ff @(posedge clk_i or negedge rstn_i) begin
        if (!rstn_i) begin
            sync      <= 3'b111; // line idles high
            busy      <= 1'b0;
            bitcnt    <= '0;
            baudcnt   <= '0;
            rx_done_o <= 1'b0;
        end else begin
            sync[2] <= uart_rxd_i;
            if (tick_i) begin
                sync[1] <= sync[2];
                sync[0] <= sync[1];
            end
            rx_done_o <= 1'b0;
            if (!enable_i) begin
                busy <= 1'b0;
            end else if (!busy) begin
                baudcnt <= baud_i >> 1; // half bit, lands mid-bit
                bitcnt  <= uart_pkg::RX_BITS;
                if (sync[1:0] == 2'b01) busy <= 1'b1; // falling edge
            end else begin
                if (tick_i) begin
                    if (baudcnt == '0) begin
                        baudcnt <= baud_i;
                        bitcnt  <= bitcnt - 1'b1;
                    end else begin
                        baudcnt <= baudcnt - 1'b1;
                    end
                end
                if (bitcnt == '0) begin // all bits in
                    rx_done_o <= 1'b1;
                    busy      <= 1'b0;
                end
            end
        end
    end

    // sample register, payload only
    always_ff @(posedge clk_i) begin
        if (enable_i && busy && tick_i && baudcnt == '0) begin
            sreg <= {sync[2], sreg[uart_pkg::DATA_W+1:1]}; // lsb first
        end
    end

endmodule

// File: uart_top.f
uart_pkg.sv
uart_fifo.sv
uart_baud_tick.sv
uart_tx.sv
uart_rx.sv
uart_regs.sv
uart_top.sv
tb_uart_top.sv

// File: uart_top.sv
// --------------------
// uart top level
// control module, baud tick, tx/rx engines and fifos
// --------------------
`timescale 1ns/1ps

module uart_top (
    input  logic                       clk_i,
    input  logic                       rstn_i,
    input  logic [uart_pkg::ADDR_W-1:0] addr_i,
    input  logic                       rden_i,
    input  logic                       wren_i,
    input  logic [uart_pkg::BUS_W-1:0]  data_i,
    output logic [uart_pkg::BUS_W-1:0]  data_o,
    output logic                       ack_o,
    output logic                       uart_txd_o,
    input  logic                       uart_rxd_i,
    output logic                       uart_rts_o,
    input  logic                       uart_cts_i,
    output logic                       irq_rx_o,
    output logic                       irq_tx_o
);
    logic                        enable, fifo_clear, hwfc_en, tick;
    logic [uart_pkg::PRSC_W-1:0] prsc;
    logic [uart_pkg::BAUD_W-1:0] baud;
    logic                        tx_we, tx_re, tx_avail, tx_half, tx_free, tx_busy;
    logic                        rx_re, rx_avail, rx_half, rx_free, rx_done;
    logic [uart_pkg::DATA_W-1:0] tx_rdata, rx_rdata, rx_data;

    uart_regs u_regs (
        .clk_i, .rstn_i, .addr_i, .rden_i, .wren_i, .data_i, .data_o, .ack_o,
        .rx_rdata_i   (rx_rdata),
        .rx_avail_i   (rx_avail),
        .rx_half_i    (rx_half),
        .rx_free_i    (rx_free),
        .tx_avail_i   (tx_avail),
        .tx_half_i    (tx_half),
        .tx_free_i    (tx_free),
        .tx_busy_i    (tx_busy),
        .rx_done_i    (rx_done),
        .enable_o     (enable),
        .fifo_clear_o (fifo_clear),
        .hwfc_en_o    (hwfc_en),
        .prsc_o       (prsc),
        .baud_o       (baud),
        .tx_we_o      (tx_we),
        .rx_re_o      (rx_re),
        .irq_rx_o, .irq_tx_o, .uart_rts_o
    );

    uart_baud_tick u_tick (
        .clk_i, .rstn_i, .enable_i (enable), .prsc_i (prsc), .tick_o (tick)
    );

    // tx path -------------
    uart_fifo #(.DEPTH(uart_pkg::FIFO_DEPTH)) u_tx_fifo (
        .clk_i, .rstn_i, .clear_i (fifo_clear),
        .we_i (tx_we), .wdata_i (data_i[uart_pkg::DATA_W-1:0]), // bus low byte
        .re_i (tx_re), .rdata_o (tx_rdata),
        .free_o (tx_free), .avail_o (tx_avail), .half_o (tx_half)
    );

    uart_tx u_tx (
        .clk_i, .rstn_i, .enable_i (enable), .tick_i (tick), .baud_i (baud),
        .hwfc_en_i (hwfc_en), .uart_cts_i,
        .fifo_avail_i (tx_avail), .fifo_rdata_i (tx_rdata), .fifo_re_o (tx_re),
        .busy_o (tx_busy), .uart_txd_o
    );

    // rx path -------------
    uart_rx u_rx (
        .clk_i, .rstn_i, .enable_i (enable), .tick_i (tick), .baud_i (baud),
        .uart_rxd_i, .rx_done_o (rx_done), .rx_data_o (rx_data)
    );

    uart_fifo #(.DEPTH(uart_pkg::FIFO_DEPTH)) u_rx_fifo (
        .clk_i, .rstn_i, .clear_i (fifo_clear),
        .we_i (rx_done), .wdata_i (rx_data), // dropped when full
        .re_i (rx_re), .rdata_o (rx_rdata),
        .free_o (rx_free), .avail_o (rx_avail), .half_o (rx_half)
    );

endmodule

// File: uart_tx.sv
// --------------------
// uart transmit engine
// idle / prepare / send fsm, shifts start, data lsb first,
// stop and one pause bit, waits on cts when flow control is on
// --------------------
`timescale 1ns/1ps

module uart_tx (
    input  logic                       clk_i,
    input  logic                       rstn_i,
    input  logic                       enable_i,
    input  logic                       tick_i,
    input  logic [uart_pkg::BAUD_W-1:0] baud_i,
    input  logic                       hwfc_en_i,
    input  logic                       uart_cts_i,   // low active
    input  logic                       fifo_avail_i,
    input  logic [uart_pkg::DATA_W-1:0] fifo_rdata_i,
    output logic                       fifo_re_o,
    output logic                       busy_o,
    output logic                       uart_txd_o
);
    logic [1:0]                  state;    // 00 idle, 01 prepare, 11 send
    logic [1:0]                  cts_sync;
    logic [uart_pkg::DATA_W:0]   sreg;     // data + start bit
    logic [3:0]                  bitcnt;
    logic [uart_pkg::BAUD_W-1:0] baudcnt;

    assign fifo_re_o  = enable_i & (state == 2'b00) & fifo_avail_i;
    assign busy_o     = (state != 2'b00);
    assign uart_txd_o = (state == 2'b11) ? sreg[0] : 1'b1; // idle high

    always_ff @(posedge clk_i or negedge rstn_i) begin
        if (!rstn_i) begin
            state    <= 2'b00;
            cts_sync <= 2'b00;
            bitcnt   <= '0;
            baudcnt  <= '0;
        end else begin
            cts_sync <= {cts_sync[0], uart_cts_i};
            if (!enable_i) begin
                state <= 2'b00;
            end else begin
                case (state)
                    2'b00: begin // wait for fifo data
                        baudcnt <= baud_i;
                        bitcnt  <= uart_pkg::TX_BITS;
                        if (fifo_avail_i) state <= 2'b01;
                    end
                    2'b01: begin // rdata valid now, check cts
                        if (!cts_sync[1] || !hwfc_en_i) state <= 2'b11;
                    end
                    2'b11: begin
                        if (tick_i) begin
                            if (baudcnt == '0) begin // bit done
                                baudcnt <= baud_i;
                                bitcnt  <= bitcnt - 1'b1;
                            end else begin
                                baudcnt <= baudcnt - 1'b1;
                            end
                        end
                        if (bitcnt == '0) state <= 2'b00; // frame + pause out
                    end
                    default: state <= 2'b00;
                endcase
            end
        end
    end

    // shift register, payload only
    always_ff @(posedge clk_i) begin
        if (state == 2'b01) begin
            sreg <= {fifo_rdata_i, 1'b0}; // data & start bit
        end else if (state == 2'b11 && tick_i && baudcnt == '0) begin
            sreg <= {1'b1, sreg[uart_pkg::DATA_W:1]}; // ones fill stop and pause
        end
    end

endmodule
